// ==== verilog/diffeq_data_pkg.sv ====
package diffeq_data_pkg;

  // word size of every numeric field
  parameter int data_width = 32;

  // one solve request from the host
  // start point (x, y, u = y'), end bound a, step dx
  typedef struct packed {
    logic [7:0]            job_id;
    logic [data_width-1:0] x;
    logic [data_width-1:0] y;
    logic [data_width-1:0] u;
    logic [data_width-1:0] a;
    logic [data_width-1:0] dx;
  } job_t;

  // final state of one solve
  typedef struct packed {
    logic [7:0]            job_id;
    logic [data_width-1:0] x;
    logic [data_width-1:0] y;
    logic [data_width-1:0] u;
    // number of euler steps actually taken
    logic [15:0]           steps;
    // loop hit the step cap before x reached a
    logic                  capped;
  } result_t;

endpackage

// ==== verilog/diffeq_ctrl_pkg.sv ====
package diffeq_ctrl_pkg;

  // issue sequence number, wraps freely
  // only two jobs in flight, so 4 bits is plenty
  typedef logic [3:0] tag_t;

  // dispatcher to core
  typedef struct packed {
    tag_t                  tag;
    diffeq_data_pkg::job_t job;
  } tagged_job_t;

  // core to merger
  // tag is stripped again by the merger
  typedef struct packed {
    tag_t                     tag;
    diffeq_data_pkg::result_t res;
  } tagged_result_t;

endpackage

// ==== verilog/diffeq_core.sv ====
`timescale 1ns/1ps

module diffeq_core #(
  parameter int max_steps = 1000
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            job_valid,
  input  diffeq_ctrl_pkg::tagged_job_t    job,
  output logic                            job_ready,
  output logic                            res_valid,
  output diffeq_ctrl_pkg::tagged_result_t res,
  input  logic                            res_ready
);

  localparam int w = diffeq_data_pkg::data_width;
  // step counter compares against this
  localparam logic [15:0] step_cap = 16'(max_steps);

  typedef enum logic [1:0] {
    st_idle,
    st_iterate,
    st_hold
  } state_t;

  state_t state;

  // solver state
  logic [w-1:0] x_q;
  logic [w-1:0] y_q;
  logic [w-1:0] u_q;
  logic [15:0]  steps_q;
  logic         capped_q;
  diffeq_ctrl_pkg::tag_t tag_q;

  // job constants kept for the whole solve
  logic [w-1:0] a_q;
  logic [w-1:0] dx_q;
  logic [7:0]   job_id_q;

  // next-step datapath
  logic [w-1:0] temp;
  logic [w-1:0] x_next;
  logic [w-1:0] y_next;
  logic [w-1:0] u_next;
  logic         keep_going;

  // one forward euler step of y'' + 3xy' + 3y = 0
  // all unsigned math wrapping at 32 bits
  always_comb
  begin
    temp   = u_q * dx_q;
    u_next = u_q - 3 * temp * x_q - 3 * dx_q * y_q;
    y_next = y_q + temp;
    x_next = x_q + dx_q;
  end

  // unsigned loop test against end bound and step cap
  assign keep_going = (x_q < a_q) && (steps_q < step_cap);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= st_idle;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          // load start point on accept
          if (job_valid)
          begin
            x_q      <= job.job.x;
            y_q      <= job.job.y;
            u_q      <= job.job.u;
            a_q      <= job.job.a;
            dx_q     <= job.job.dx;
            job_id_q <= job.job.job_id;
            tag_q    <= job.tag;
            steps_q  <= '0;
            capped_q <= 1'b0;
            state    <= st_iterate;
          end
        end
        st_iterate:
        begin
          if (keep_going)
          begin
            x_q     <= x_next;
            y_q     <= y_next;
            u_q     <= u_next;
            steps_q <= steps_q + 16'd1;
          end
          else
          begin
            // still below a means we ran out of steps
            capped_q <= (x_q < a_q);
            state    <= st_hold;
          end
        end
        st_hold:
        begin
          // wait for the merger to take it
          if (res_ready)
            state <= st_idle;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  assign job_ready = (state == st_idle);
  assign res_valid = (state == st_hold);

  // result comes straight from the state registers
  assign res.tag        = tag_q;
  assign res.res.job_id = job_id_q;
  assign res.res.x      = x_q;
  assign res.res.y      = y_q;
  assign res.res.u      = u_q;
  assign res.res.steps  = steps_q;
  assign res.res.capped = capped_q;

endmodule

// ==== verilog/diffeq_dispatch.sv ====
`timescale 1ns/1ps

module diffeq_dispatch (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         job_valid,
  input  diffeq_data_pkg::job_t        job,
  output logic                         job_ready,
  output diffeq_ctrl_pkg::tagged_job_t core_job,
  output logic                         core0_job_valid,
  input  logic                         core0_job_ready,
  output logic                         core1_job_valid,
  input  logic                         core1_job_ready
);

  // tag for the next accepted job
  diffeq_ctrl_pkg::tag_t issue_tag;

  logic take0;
  logic take1;
  logic accept;

  // core 0 wins when both are free
  assign take0 = core0_job_ready;
  assign take1 = core1_job_ready && !core0_job_ready;

  // host sees ready whenever some core is idle
  assign job_ready = core0_job_ready || core1_job_ready;

  // valid only goes to the chosen core
  assign core0_job_valid = job_valid && take0;
  assign core1_job_valid = job_valid && take1;

  // shared payload, stamped with the issue tag
  assign core_job.tag = issue_tag;
  assign core_job.job = job;

  assign accept = job_valid && job_ready;

  // one tag per accepted job
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      issue_tag <= '0;
    end
    else if (accept)
    begin
      issue_tag <= issue_tag + 4'd1;
    end
  end

endmodule

// ==== verilog/diffeq_result_merge.sv ====
`timescale 1ns/1ps

module diffeq_result_merge (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            core0_res_valid,
  input  diffeq_ctrl_pkg::tagged_result_t core0_res,
  output logic                            core0_res_ready,
  input  logic                            core1_res_valid,
  input  diffeq_ctrl_pkg::tagged_result_t core1_res,
  output logic                            core1_res_ready,
  output logic                            out_valid,
  output diffeq_data_pkg::result_t        out,
  input  logic                            out_ready
);

  // tag of the next result owed to the host
  diffeq_ctrl_pkg::tag_t expect_tag;

  logic hit0;
  logic hit1;
  logic fire;

  // a core only counts once its result carries the expected tag
  // a finished core with a later tag just sits in hold
  assign hit0 = core0_res_valid && (core0_res.tag == expect_tag);
  assign hit1 = core1_res_valid && (core1_res.tag == expect_tag);

  assign out_valid = hit0 || hit1;

  // at most one core holds the expected tag
  always_comb
  begin
    if (hit0)
      out = core0_res.res;
    else
      out = core1_res.res;
  end

  // ready back only to the selected core
  assign core0_res_ready = hit0 && out_ready;
  assign core1_res_ready = hit1 && !hit0 && out_ready;

  assign fire = out_valid && out_ready;

  // move on to the next issue slot
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      expect_tag <= '0;
    end
    else if (fire)
    begin
      expect_tag <= expect_tag + 4'd1;
    end
  end

endmodule

// ==== verilog/diffeq_top.sv ====
`timescale 1ns/1ps

module diffeq_top #(
  parameter int max_steps = 1000
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     job_valid,
  input  diffeq_data_pkg::job_t    job,
  output logic                     job_ready,
  output logic                     out_valid,
  output diffeq_data_pkg::result_t out,
  input  logic                     out_ready
);

  // dispatcher to cores
  diffeq_ctrl_pkg::tagged_job_t core_job;
  logic core0_job_valid;
  logic core0_job_ready;
  logic core1_job_valid;
  logic core1_job_ready;

  // cores to merger
  diffeq_ctrl_pkg::tagged_result_t core0_res;
  diffeq_ctrl_pkg::tagged_result_t core1_res;
  logic core0_res_valid;
  logic core0_res_ready;
  logic core1_res_valid;
  logic core1_res_ready;

  diffeq_dispatch i_dispatch (
    .clk             (clk),
    .reset           (reset),
    .job_valid       (job_valid),
    .job             (job),
    .job_ready       (job_ready),
    .core_job        (core_job),
    .core0_job_valid (core0_job_valid),
    .core0_job_ready (core0_job_ready),
    .core1_job_valid (core1_job_valid),
    .core1_job_ready (core1_job_ready)
  );

  // both cores share the job bus, valid picks the target
  diffeq_core #(
    .max_steps (max_steps)
  ) i_core0 (
    .clk       (clk),
    .reset     (reset),
    .job_valid (core0_job_valid),
    .job       (core_job),
    .job_ready (core0_job_ready),
    .res_valid (core0_res_valid),
    .res       (core0_res),
    .res_ready (core0_res_ready)
  );

  diffeq_core #(
    .max_steps (max_steps)
  ) i_core1 (
    .clk       (clk),
    .reset     (reset),
    .job_valid (core1_job_valid),
    .job       (core_job),
    .job_ready (core1_job_ready),
    .res_valid (core1_res_valid),
    .res       (core1_res),
    .res_ready (core1_res_ready)
  );

  // puts results back in issue order
  diffeq_result_merge i_merge (
    .clk             (clk),
    .reset           (reset),
    .core0_res_valid (core0_res_valid),
    .core0_res       (core0_res),
    .core0_res_ready (core0_res_ready),
    .core1_res_valid (core1_res_valid),
    .core1_res       (core1_res),
    .core1_res_ready (core1_res_ready),
    .out_valid       (out_valid),
    .out             (out),
    .out_ready       (out_ready)
  );

endmodule

// ==== sim/diffeq_ref_model.svh ====
`ifndef diffeq_ref_model_svh
`define diffeq_ref_model_svh

// entries in the stimulus table
localparam int num_jobs = 10;

// one forward euler step, all math wraps at 32 bits
function automatic diffeq_data_pkg::result_t euler_step(
  input diffeq_data_pkg::result_t s,
  input logic [31:0]              dx
);
  diffeq_data_pkg::result_t n;
  logic [31:0]              temp;
  temp    = s.u * dx;
  n       = s;
  // old x and y feed the u update
  n.u     = s.u - 32'd3 * temp * s.x - 32'd3 * dx * s.y;
  n.y     = s.y + temp;
  n.x     = s.x + dx;
  n.steps = s.steps + 16'd1;
  return n;
endfunction

// full solve, loop until x reaches a or the cap is hit
function automatic diffeq_data_pkg::result_t solve_job(
  input diffeq_data_pkg::job_t j,
  input int                    cap
);
  diffeq_data_pkg::result_t r;
  r.job_id = j.job_id;
  r.x      = j.x;
  r.y      = j.y;
  r.u      = j.u;
  r.steps  = '0;
  r.capped = 1'b0;
  while ((r.x < j.a) && (r.steps < cap))
    r = euler_step(r, j.dx);
  // still short of a means the cap stopped it
  r.capped = (r.x < j.a);
  return r;
endfunction

function automatic diffeq_data_pkg::job_t make_job(
  input logic [7:0]  id,
  input logic [31:0] x,
  input logic [31:0] y,
  input logic [31:0] u,
  input logic [31:0] a,
  input logic [31:0] dx
);
  diffeq_data_pkg::job_t j;
  j.job_id = id;
  j.x      = x;
  j.y      = y;
  j.u      = u;
  j.a      = a;
  j.dx     = dx;
  return j;
endfunction

// stimulus table: id, x, y, u, a, dx
function automatic diffeq_data_pkg::job_t table_job(input int idx);
  case (idx)
    0:       return make_job(8'h11, 32'd0,  32'd3,  32'd2,  32'd10,  32'd1);
    1:       return make_job(8'h22, 32'd20, 32'd5,  32'd4,  32'd10,  32'd1);
    2:       return make_job(8'h33, 32'd0,  32'd7,  32'd1,  32'd5,   32'd0);
    // long then short, core 1 tends to finish first
    3:       return make_job(8'h44, 32'd0,  32'd1,  32'd1,  32'd60,  32'd1);
    4:       return make_job(8'h55, 32'd0,  32'd2,  32'd3,  32'd2,   32'd1);
    5:       return make_job(8'h66, 32'd5,  32'd9,  32'd6,  32'd50,  32'd1);
    6:       return make_job(8'h77, 32'd0,  32'd4,  32'd8,  32'd3,   32'd1);
    7:       return make_job(8'h88, 32'd0,  32'd2,  32'd2,  32'd100, 32'd1);
    8:       return make_job(8'h99, 32'd9,  32'd6,  32'd5,  32'd10,  32'd1);
    default: return make_job(8'haa, 32'd0,  32'd3,  32'd7,  32'd30,  32'd2);
  endcase
endfunction

function automatic string table_name(input int idx);
  case (idx)
    0:       return "normal";
    1:       return "start_done";
    2:       return "dx_zero_cap";
    3, 4, 5, 6: return "ordering";
    default: return "backpressure";
  endcase
endfunction

`endif

// ==== sim/diffeq_tb.sv ====
`timescale 1ns/1ps

module diffeq_tb;

  // step cap, shared by dut and model
  localparam int step_cap = 64;
  // cycles any single wait may take
  localparam int wait_limit = 2000;

  logic                     clk;
  logic                     reset;
  logic                     job_valid;
  diffeq_data_pkg::job_t    job;
  logic                     job_ready;
  logic                     out_valid;
  diffeq_data_pkg::result_t out;
  logic                     out_ready;

  integer seed;

  // expected results and test names in issue order
  diffeq_data_pkg::result_t exp_q[$];
  string                    name_q[$];

  `include "diffeq_ref_model.svh"

  diffeq_top #(
    .max_steps (step_cap)
  ) i_dut (
    .clk       (clk),
    .reset     (reset),
    .job_valid (job_valid),
    .job       (job),
    .job_ready (job_ready),
    .out_valid (out_valid),
    .out       (out),
    .out_ready (out_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic compare_field(
    input string       test,
    input string       field,
    input logic [31:0] exp,
    input logic [31:0] act
  );
    assert (act === exp)
    else
      stop_on_error($sformatf("Mismatch test=%s field=%s expected=%0h actual=%0h",
                              test, field, exp, act));
  endtask

  // every field of one result against the model
  task automatic check_result(
    input string                    test,
    input diffeq_data_pkg::result_t exp,
    input diffeq_data_pkg::result_t act
  );
    compare_field(test, "job_id", 32'(exp.job_id), 32'(act.job_id));
    compare_field(test, "x", exp.x, act.x);
    compare_field(test, "y", exp.y, act.y);
    compare_field(test, "u", exp.u, act.u);
    compare_field(test, "steps", 32'(exp.steps), 32'(act.steps));
    compare_field(test, "capped", 32'(exp.capped), 32'(act.capped));
  endtask

  // random back-pressure plus output checking
  // outputs come from registers, so they are settled at the falling edge
  task automatic monitor_outputs();
    diffeq_data_pkg::result_t want;
    string                    test;
    forever
    begin
      @(negedge clk);
      // ready about three cycles out of four
      out_ready = (($random(seed) & 3) != 0);
      if (out_valid && out_ready)
      begin
        assert (exp_q.size() != 0)
        else
          stop_on_error("result delivered while no job was outstanding");
        want = exp_q.pop_front();
        test = name_q.pop_front();
        check_result(test, want, out);
      end
    end
  endtask

  initial
  begin
    int                    idx;
    int                    waited;
    diffeq_data_pkg::job_t next_job;
    seed      = 32'hcf5d;
    reset     = 1'b1;
    job_valid = 1'b0;
    job       = '0;
    out_ready = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    // idle state right after reset
    assert (out_valid === 1'b0)
    else
      stop_on_error("out_valid is high after reset before any job was sent");
    assert (job_ready === 1'b1)
    else
      stop_on_error("job_ready is low after reset before any job was sent");
    fork
      monitor_outputs();
    join_none
    // push the table in order
    for (idx = 0; idx < num_jobs; idx++)
    begin
      next_job  = table_job(idx);
      job_valid = 1'b1;
      job       = next_job;
      waited    = 0;
      while (!job_ready)
      begin
        @(negedge clk);
        waited++;
        assert (waited <= wait_limit)
        else
          stop_on_error("timeout waiting for job_ready");
      end
      // accepted on the coming rising edge
      exp_q.push_back(solve_job(next_job, step_cap));
      name_q.push_back(table_name(idx));
      @(negedge clk);
    end
    job_valid = 1'b0;
    job       = '0;
    // drain
    waited = 0;
    while (exp_q.size() != 0)
    begin
      @(negedge clk);
      waited++;
      assert (waited <= wait_limit)
      else
        stop_on_error("timeout waiting for the remaining results");
    end
    // quiet period, any extra output trips the monitor
    repeat (20) @(negedge clk);
    assert (out_valid === 1'b0)
    else
      stop_on_error("out_valid still high after every result was delivered");
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+sim
verilog/diffeq_data_pkg.sv
verilog/diffeq_ctrl_pkg.sv
verilog/diffeq_core.sv
verilog/diffeq_dispatch.sv
verilog/diffeq_result_merge.sv
verilog/diffeq_top.sv
sim/diffeq_tb.sv
